// File: verilog/an_params.svh
// Clause 37 auto-negotiation parameters
// Link timer length, match depth and the advertised configuration word
`ifndef AN_PARAMS_SVH
`define AN_PARAMS_SVH

// 10 ms link timer at 125 MHz
`define AN_LINK_TIMER_TICKS 1250000

// Consecutive agreeing sets required for any match
`define AN_MATCH_COUNT 3

// Full duplex only, no pause, no next page
`define AN_ADV_ABILITY 16'h0020

// Acknowledge bit in a configuration word
`define AN_ACK_BIT 14

`endif

// File: verilog/an_code_pkg.sv
// Line code definitions for the 8-bit decoded symbol interface
// Decoded byte values of the ordered-set codes and the received set kinds
package an_code_pkg;

  // Comma, sent with the K flag
  localparam logic [7:0] K28_5 = 8'hbc;

  // Second byte of C1 and C2 configuration sets
  localparam logic [7:0] D21_5 = 8'hb5;
  localparam logic [7:0] D2_2  = 8'h42;

  // Second byte of I1 and I2 idle sets
  localparam logic [7:0] D5_6  = 8'hc5;
  localparam logic [7:0] D16_2 = 8'h50;

  typedef enum logic [1:0] {
    OS_NONE   = 2'd0,
    OS_CONFIG = 2'd1,
    OS_IDLE   = 2'd2
  } os_kind_t;

endpackage

// File: verilog/an_ctrl_pkg.sv
// Negotiation control types
// Arbitration states and transmit modes shared by arbiter and transmitter
package an_ctrl_pkg;

  typedef enum logic [3:0] {
    AN_ENABLE               = 4'h0,
    AN_RESTART              = 4'h1,
    ABILITY_DETECT          = 4'h2,
    ABILITY_DETECT_WAIT     = 4'h3,
    ACKNOWLEDGE_DETECT      = 4'h4,
    ACKNOWLEDGE_DETECT_WAIT = 4'h5,
    COMPLETE_ACKNOWLEDGE    = 4'h6,
    IDLE_DETECT             = 4'h7,
    LINK_OK                 = 4'h8
  } an_state_t;

  typedef enum logic [1:0] {
    XMIT_IDLE          = 2'd0,
    XMIT_CONFIGURATION = 2'd1,
    XMIT_DATA          = 2'd2
  } xmit_mode_t;

endpackage

// File: verilog/cr_match_if.sv
// Receiver to arbiter link
// Received configuration word, match flags and the arbiter's clear strobes
`timescale 1ns/1ps

interface cr_match_if;
  logic [15:0] config_reg;
  logic        cr_stb;
  logic        ability_match;
  logic        acknowledge_match;
  logic        consistency_match;
  logic        idle_match;

  // Driven by the arbiter
  logic        ability_phase;
  logic        clear_ability;
  logic        clear_ack;
  logic        clear_consistency;
  logic        clear_idle;
  logic        clear_all;

  modport rx (
    output config_reg, cr_stb, ability_match, acknowledge_match,
           consistency_match, idle_match,
    input  ability_phase, clear_ability, clear_ack, clear_consistency,
           clear_idle, clear_all
  );

  modport arb (
    input  config_reg, cr_stb, ability_match, acknowledge_match,
           consistency_match, idle_match,
    output ability_phase, clear_ability, clear_ack, clear_consistency,
           clear_idle, clear_all
  );
endinterface

// File: verilog/cr_receiver.sv
// Configuration receiver
// Parses /C/ and /I/ ordered sets from the decoded byte stream and runs
// the ability, acknowledge, consistency and idle match detectors
`timescale 1ns/1ps
`include "an_params.svh"

module cr_receiver (
  input  logic       clk,
  input  logic       mr_main_reset,
  input  logic [7:0] rx_byte,
  input  logic       rx_is_k,
  cr_match_if.rx     m
);

  typedef enum logic [1:0] {
    P_IDLE    = 2'd0,
    P_GOT_K   = 2'd1,
    P_CR_LOW  = 2'd2,
    P_CR_HIGH = 2'd3
  } parse_state_t;

  localparam logic [1:0]  match_last = 2'(`AN_MATCH_COUNT - 1);
  localparam logic [15:0] ack_mask   = 16'(1) << `AN_ACK_BIT;

  logic [7:0]            rx_byte_q;
  logic                  rx_is_k_q;
  parse_state_t          parse_state;
  an_code_pkg::os_kind_t rx_kind;
  logic                  idle_seen;
  logic [7:0]            low_byte;
  logic [15:0]           prev_word;
  logic [15:0]           cons_ref;
  logic [1:0]            ability_cnt;
  logic [1:0]            ack_cnt;
  logic [1:0]            idle_cnt;
  logic                  ability_agree;
  logic                  ack_agree;
  logic                  cons_agree;

  // Input register, adds one clock ahead of the parser
  always_ff @(posedge clk) begin
    rx_byte_q <= rx_byte;
    rx_is_k_q <= rx_is_k;
  end

  // Kind of set announced by the byte after a comma
  always_comb begin
    rx_kind = an_code_pkg::OS_NONE;
    if (!rx_is_k_q) begin
      case (rx_byte_q)
        an_code_pkg::D21_5, an_code_pkg::D2_2: rx_kind = an_code_pkg::OS_CONFIG;
        an_code_pkg::D5_6, an_code_pkg::D16_2: rx_kind = an_code_pkg::OS_IDLE;
        default:                               rx_kind = an_code_pkg::OS_NONE;
      endcase
    end
  end

  assign idle_seen = (parse_state == P_GOT_K) && (rx_kind == an_code_pkg::OS_IDLE);

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      parse_state <= P_IDLE;
      m.cr_stb    <= 1'b0;
    end else begin
      m.cr_stb <= 1'b0;
      case (parse_state)
        P_GOT_K: begin
          if (rx_kind == an_code_pkg::OS_CONFIG) parse_state <= P_CR_LOW;
          else parse_state <= P_IDLE;
        end
        P_CR_LOW: parse_state <= P_CR_HIGH;
        P_CR_HIGH: begin
          parse_state <= P_IDLE;
          m.cr_stb    <= 1'b1;
        end
        default: begin
          if (rx_is_k_q && (rx_byte_q == an_code_pkg::K28_5)) parse_state <= P_GOT_K;
        end
      endcase
    end
  end

  // Word assembly, previous word and consistency reference
  always_ff @(posedge clk) begin
    if (parse_state == P_CR_LOW) low_byte <= rx_byte_q;
    if (parse_state == P_CR_HIGH) m.config_reg <= {rx_byte_q, low_byte};
    if (m.cr_stb) begin
      prev_word <= m.config_reg;
      if (m.ability_phase) cons_ref <= m.config_reg;
    end
  end

  assign ability_agree = (m.config_reg & ~ack_mask) == (prev_word & ~ack_mask);
  assign ack_agree     = m.config_reg[`AN_ACK_BIT] && (m.config_reg == prev_word);
  assign cons_agree    = (m.config_reg & ~ack_mask) == (cons_ref & ~ack_mask);

  // Counters hold at their last value once the flag is up
  always_ff @(posedge clk) begin
    if (mr_main_reset || m.clear_all) begin
      m.ability_match     <= 1'b0;
      m.acknowledge_match <= 1'b0;
      m.consistency_match <= 1'b0;
      m.idle_match        <= 1'b0;
      ability_cnt         <= 2'd0;
      ack_cnt             <= 2'd0;
      idle_cnt            <= 2'd0;
    end else begin
      if (m.clear_ability) begin
        m.ability_match <= 1'b0;
        ability_cnt     <= 2'd0;
      end else if (m.cr_stb && !m.ability_match) begin
        if (!ability_agree) ability_cnt <= 2'd0;
        else if (ability_cnt == match_last) m.ability_match <= 1'b1;
        else ability_cnt <= ability_cnt + 2'd1;
      end

      if (m.clear_consistency) m.consistency_match <= 1'b0;

      if (m.clear_ack) begin
        m.acknowledge_match <= 1'b0;
        ack_cnt             <= 2'd0;
      end else if (m.cr_stb && !m.acknowledge_match) begin
        if (!ack_agree) begin
          ack_cnt <= 2'd0;
        end else if (ack_cnt == match_last) begin
          m.acknowledge_match <= 1'b1;
          // Partner must acknowledge the same abilities it advertised
          m.consistency_match <= cons_agree;
        end else begin
          ack_cnt <= ack_cnt + 2'd1;
        end
      end

      if (m.clear_idle) begin
        m.idle_match <= 1'b0;
        idle_cnt     <= 2'd0;
      end else if (idle_seen && !m.idle_match) begin
        if (idle_cnt == match_last) m.idle_match <= 1'b1;
        else idle_cnt <= idle_cnt + 2'd1;
      end
    end
  end

endmodule

// File: verilog/an_arbiter.sv
// Clause 37 arbitration state machine
// Sequences the configuration exchange with the link timer, selects the
// transmit mode and word, and handles breaklink and loss of signal
`timescale 1ns/1ps
`include "an_params.svh"

module an_arbiter #(
  parameter int link_timer_ticks = `AN_LINK_TIMER_TICKS
) (
  input  logic                    clk,
  input  logic                    mr_main_reset,
  input  logic                    los,
  cr_match_if.arb                 m,
  output an_ctrl_pkg::xmit_mode_t xmit_mode,
  output logic [15:0]             tx_config,
  output logic                    xmit_restart,
  output logic                    negotiating
);

  localparam int timer_w = (link_timer_ticks > 1) ? $clog2(link_timer_ticks) : 1;
  localparam logic [timer_w-1:0] timer_max = timer_w'(link_timer_ticks - 1);

  an_ctrl_pkg::an_state_t state;
  logic                   link_det;
  logic [timer_w-1:0]     timer_cnt;
  logic                   timer_en;
  logic                   timer_exp;
  logic                   timer_start;
  logic                   started;
  logic                   phase_done;
  logic                   breaklink;

  assign negotiating     = state != an_ctrl_pkg::LINK_OK;
  assign m.ability_phase = (state == an_ctrl_pkg::ABILITY_DETECT) ||
                           (state == an_ctrl_pkg::ABILITY_DETECT_WAIT);
  assign breaklink       = m.ability_match && (m.config_reg == 16'h0000);

  // Timed states start one phase on their first cycle
  assign timer_start = !started && ((state == an_ctrl_pkg::AN_RESTART) ||
                                    (state == an_ctrl_pkg::COMPLETE_ACKNOWLEDGE) ||
                                    (state == an_ctrl_pkg::IDLE_DETECT));
  assign phase_done  = started && timer_exp;

  always_ff @(posedge clk) begin
    if (mr_main_reset || los) link_det <= 1'b0;
    else if (m.cr_stb) link_det <= 1'b1;
  end

  // Link timer, timer_exp stays up until the next start
  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      timer_cnt <= '0;
      timer_en  <= 1'b0;
      timer_exp <= 1'b0;
    end else if (timer_start) begin
      timer_cnt <= '0;
      timer_en  <= 1'b1;
      timer_exp <= 1'b0;
    end else if (timer_en) begin
      if (timer_cnt == timer_max) begin
        timer_en  <= 1'b0;
        timer_exp <= 1'b1;
      end else begin
        timer_cnt <= timer_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mr_main_reset) begin
      state               <= an_ctrl_pkg::AN_ENABLE;
      xmit_mode           <= an_ctrl_pkg::XMIT_IDLE;
      tx_config           <= 16'h0000;
      // Held during reset so the transmitter starts on a set boundary
      xmit_restart        <= 1'b1;
      started             <= 1'b0;
      m.clear_ability     <= 1'b0;
      m.clear_ack         <= 1'b0;
      m.clear_consistency <= 1'b0;
      m.clear_idle        <= 1'b0;
      m.clear_all         <= 1'b0;
    end else begin
      xmit_restart        <= 1'b0;
      m.clear_ability     <= 1'b0;
      m.clear_ack         <= 1'b0;
      m.clear_consistency <= 1'b0;
      m.clear_idle        <= 1'b0;
      m.clear_all         <= 1'b0;
      started             <= started | timer_start;
      case (state)
        an_ctrl_pkg::AN_ENABLE: begin
          m.clear_all <= 1'b1;
          started     <= 1'b0;
          if (!los) begin
            tx_config    <= 16'h0000;
            xmit_mode    <= an_ctrl_pkg::XMIT_CONFIGURATION;
            xmit_restart <= 1'b1;
            state        <= an_ctrl_pkg::AN_RESTART;
          end else begin
            xmit_mode    <= an_ctrl_pkg::XMIT_IDLE;
            xmit_restart <= xmit_mode != an_ctrl_pkg::XMIT_IDLE;
          end
        end
        an_ctrl_pkg::AN_RESTART: begin
          if (phase_done) begin
            // Without link detect run another phase
            started <= 1'b0;
            if (link_det) begin
              m.clear_ability <= 1'b1;
              state           <= an_ctrl_pkg::ABILITY_DETECT;
            end
          end
        end
        an_ctrl_pkg::ABILITY_DETECT: begin
          tx_config <= `AN_ADV_ABILITY;
          state     <= an_ctrl_pkg::ABILITY_DETECT_WAIT;
        end
        an_ctrl_pkg::ABILITY_DETECT_WAIT: begin
          if (breaklink) begin
            state <= an_ctrl_pkg::AN_ENABLE;
          end else if (m.ability_match) begin
            m.clear_ack         <= 1'b1;
            m.clear_consistency <= 1'b1;
            state               <= an_ctrl_pkg::ACKNOWLEDGE_DETECT;
          end
        end
        an_ctrl_pkg::ACKNOWLEDGE_DETECT: begin
          tx_config[`AN_ACK_BIT] <= 1'b1;
          state                  <= an_ctrl_pkg::ACKNOWLEDGE_DETECT_WAIT;
        end
        an_ctrl_pkg::ACKNOWLEDGE_DETECT_WAIT: begin
          if (breaklink || (m.acknowledge_match && !m.consistency_match)) begin
            state <= an_ctrl_pkg::AN_ENABLE;
          end else if (m.acknowledge_match) begin
            started <= 1'b0;
            state   <= an_ctrl_pkg::COMPLETE_ACKNOWLEDGE;
          end
        end
        an_ctrl_pkg::COMPLETE_ACKNOWLEDGE: begin
          if (!started) begin
            m.clear_ability <= 1'b1;
          end else if (breaklink) begin
            state <= an_ctrl_pkg::AN_ENABLE;
          end else if (phase_done) begin
            started <= 1'b0;
            state   <= an_ctrl_pkg::IDLE_DETECT;
          end
        end
        an_ctrl_pkg::IDLE_DETECT: begin
          if (!started) begin
            xmit_mode       <= an_ctrl_pkg::XMIT_IDLE;
            xmit_restart    <= 1'b1;
            m.clear_ability <= 1'b1;
            m.clear_idle    <= 1'b1;
          end else if (breaklink) begin
            state <= an_ctrl_pkg::AN_ENABLE;
          end else if (phase_done && m.idle_match) begin
            xmit_mode <= an_ctrl_pkg::XMIT_DATA;
            state     <= an_ctrl_pkg::LINK_OK;
          end
        end
        an_ctrl_pkg::LINK_OK: begin
          xmit_mode <= an_ctrl_pkg::XMIT_DATA;
          // Any new configuration from the partner restarts negotiation
          if (m.ability_match) state <= an_ctrl_pkg::AN_ENABLE;
        end
        default: state <= an_ctrl_pkg::AN_ENABLE;
      endcase
    end
  end

endmodule

// File: verilog/os_transmitter.sv
// Ordered-set transmitter
// Emits C1/C2 configuration sets, I1/I2 idle sets or zero data, one byte per clock
`timescale 1ns/1ps

module os_transmitter (
  input  logic                    clk,
  input  an_ctrl_pkg::xmit_mode_t xmit_mode,
  input  logic [15:0]             tx_config,
  input  logic                    xmit_restart,
  output logic [7:0]              tx_byte,
  output logic                    tx_is_k
);

  logic [1:0] byte_pos;
  logic       variant;
  logic [1:0] cur_pos;
  logic       cur_variant;

  // A restart makes this clock the first byte of a fresh set
  assign cur_pos     = xmit_restart ? 2'd0 : byte_pos;
  assign cur_variant = xmit_restart ? 1'b0 : variant;

  always_ff @(posedge clk) begin
    case (xmit_mode)
      an_ctrl_pkg::XMIT_CONFIGURATION: begin
        byte_pos <= cur_pos + 2'd1;
        variant  <= cur_variant;
        tx_is_k  <= 1'b0;
        case (cur_pos)
          2'd0: begin
            tx_byte <= an_code_pkg::K28_5;
            tx_is_k <= 1'b1;
          end
          2'd1: begin
            tx_byte <= cur_variant ? an_code_pkg::D21_5 : an_code_pkg::D2_2;
            variant <= ~cur_variant;
          end
          2'd2: tx_byte <= tx_config[7:0];
          default: tx_byte <= tx_config[15:8];
        endcase
      end
      an_ctrl_pkg::XMIT_IDLE: begin
        // Two-byte sets
        if (cur_pos == 2'd0) begin
          tx_byte  <= an_code_pkg::K28_5;
          tx_is_k  <= 1'b1;
          byte_pos <= 2'd1;
          variant  <= cur_variant;
        end else begin
          tx_byte  <= cur_variant ? an_code_pkg::D16_2 : an_code_pkg::D5_6;
          tx_is_k  <= 1'b0;
          byte_pos <= 2'd0;
          variant  <= ~cur_variant;
        end
      end
      default: begin
        // Data mode
        tx_byte  <= 8'h00;
        tx_is_k  <= 1'b0;
        byte_pos <= 2'd0;
        variant  <= 1'b0;
      end
    endcase
  end

endmodule

// File: verilog/clause37_an.sv
// Clause 37 auto-negotiation engine for fiber Ethernet
// Receiver, arbiter and transmitter on an 8-bit decoded symbol interface
`timescale 1ns/1ps
`include "an_params.svh"

module clause37_an #(
  parameter int link_timer_ticks = `AN_LINK_TIMER_TICKS
) (
  input  logic        clk,
  input  logic        mr_main_reset,
  input  logic [7:0]  rx_byte,
  input  logic        rx_is_k,
  input  logic        los,
  output logic [7:0]  tx_byte,
  output logic        tx_is_k,
  output logic        negotiating,
  output logic [15:0] lacr_rx_val,
  output logic        lacr_rx_stb,
  output logic [15:0] lacr_tx_val,
  output logic        lacr_send
);

  an_ctrl_pkg::xmit_mode_t xmit_mode;
  logic [15:0]             tx_config;
  logic                    xmit_restart;

  cr_match_if m_if ();

  cr_receiver u_rx (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx_byte       (rx_byte),
    .rx_is_k       (rx_is_k),
    .m             (m_if.rx)
  );

  an_arbiter #(
    .link_timer_ticks (link_timer_ticks)
  ) u_arb (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .los           (los),
    .m             (m_if.arb),
    .xmit_mode     (xmit_mode),
    .tx_config     (tx_config),
    .xmit_restart  (xmit_restart),
    .negotiating   (negotiating)
  );

  os_transmitter u_tx (
    .clk          (clk),
    .xmit_mode    (xmit_mode),
    .tx_config    (tx_config),
    .xmit_restart (xmit_restart),
    .tx_byte      (tx_byte),
    .tx_is_k      (tx_is_k)
  );

  // Management view of the exchanged words
  assign lacr_rx_val = m_if.config_reg;
  assign lacr_rx_stb = m_if.cr_stb;
  assign lacr_tx_val = tx_config;
  assign lacr_send   = xmit_mode == an_ctrl_pkg::XMIT_CONFIGURATION;

endmodule

// File: verif/an_checker.sv
// Checker for the clause 37 engine
// Decodes the transmitted set stream, checks received words and row results
`timescale 1ns/1ps

module an_checker (
  input  logic        clk,
  input  logic        mr_main_reset,
  input  logic [7:0]  tx_byte,
  input  logic        tx_is_k,
  input  logic        negotiating,
  input  logic        lacr_send,
  input  logic [15:0] lacr_tx_val,
  input  logic        lacr_rx_stb,
  input  logic [15:0] lacr_rx_val,
  input  logic [15:0] sent_word,
  input  logic        row_check,
  input  logic        exp_negotiating,
  input  logic        exp_send,
  input  logic [15:0] exp_tx_val,
  output int          table_errors,
  output int          stream_errors,
  output int          rx_errors,
  output int          stb_count
);

  int n_table  = 0;
  int n_stream = 0;
  int n_rx     = 0;
  int n_stb    = 0;

  // Port history, one and two samples back
  logic        rst_d1  = 1'b1;
  logic        rst_d2  = 1'b1;
  logic        send_d1 = 1'b0;
  logic        send_d2 = 1'b0;
  logic        neg_d1  = 1'b1;
  logic [15:0] val_d1  = 16'h0000;
  logic [15:0] val_d2  = 16'h0000;

  // Position within a set, expected variant, data mode seen
  logic [1:0] pos     = 2'd0;
  logic       var_exp = 1'b0;
  logic       in_data = 1'b0;
  logic       fresh;

  assign table_errors  = n_table;
  assign stream_errors = n_stream;
  assign rx_errors     = n_rx;
  assign stb_count     = n_stb;

  // A mode change or the word dropping to zero starts a new set with variant 0
  assign fresh = rst_d2 || (send_d1 != send_d2) ||
                 (send_d1 && (val_d1 == 16'h0000) && (val_d2 != 16'h0000));

  task automatic show_mismatch(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
    $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic expect_byte(input logic [7:0] exp_b, input logic exp_k);
    if ((tx_byte !== exp_b) || (tx_is_k !== exp_k)) begin
      $display("FAILED t=%0t tx_byte/tx_is_k expected %h/%b got %h/%b",
               $time, exp_b, exp_k, tx_byte, tx_is_k);
      n_stream++;
    end
  endtask

  // Outputs are read at the rising edge before they update
  always @(posedge clk) begin
    if (row_check) begin
      if (negotiating !== exp_negotiating) begin
        show_mismatch("negotiating", 16'(exp_negotiating), 16'(negotiating));
        n_table++;
      end
      if (lacr_send !== exp_send) begin
        show_mismatch("lacr_send", 16'(exp_send), 16'(lacr_send));
        n_table++;
      end
      if (lacr_tx_val !== exp_tx_val) begin
        show_mismatch("lacr_tx_val", exp_tx_val, lacr_tx_val);
        n_table++;
      end
    end

    if (!mr_main_reset && (lacr_rx_stb === 1'b1)) n_stb++;

    if (!mr_main_reset && lacr_rx_stb && (lacr_rx_val !== sent_word)) begin
      show_mismatch("lacr_rx_val", sent_word, lacr_rx_val);
      n_rx++;
    end

    if (mr_main_reset || rst_d1) begin
      // Stream undefined around reset
      pos <= 2'd0;
    end else if (fresh) begin
      expect_byte(an_code_pkg::K28_5, 1'b1);
      pos     <= 2'd1;
      var_exp <= 1'b0;
      in_data <= 1'b0;
    end else if (send_d1) begin
      case (pos)
        2'd0: expect_byte(an_code_pkg::K28_5, 1'b1);
        2'd1: begin
          expect_byte(var_exp ? an_code_pkg::D21_5 : an_code_pkg::D2_2, 1'b0);
          var_exp <= ~var_exp;
        end
        2'd2: expect_byte(val_d1[7:0], 1'b0);
        default: expect_byte(val_d1[15:8], 1'b0);
      endcase
      pos <= pos + 2'd1;
    end else if (!neg_d1 || in_data) begin
      expect_byte(8'h00, 1'b0);
      in_data <= 1'b1;
    end else if (pos == 2'd0) begin
      expect_byte(an_code_pkg::K28_5, 1'b1);
      pos <= 2'd1;
    end else begin
      // Idle set, a config code here means config sent without link
      expect_byte(var_exp ? an_code_pkg::D16_2 : an_code_pkg::D5_6, 1'b0);
      var_exp <= ~var_exp;
      pos     <= 2'd0;
    end

    rst_d1  <= mr_main_reset;
    rst_d2  <= rst_d1;
    send_d1 <= lacr_send;
    send_d2 <= send_d1;
    neg_d1  <= negotiating;
    val_d1  <= lacr_tx_val;
    val_d2  <= val_d1;
  end

endmodule

// File: verif/tb_clause37_an.sv
// Testbench for the clause 37 auto-negotiation engine
// Plays a link partner from a stimulus table and checks the engine's responses
`timescale 1ns/1ps

module tb_clause37_an;

  localparam int timer_ticks  = 64;
  localparam int reset_cycles = 10;
  localparam int n_rows       = 9;

  // Partner actions
  localparam logic [1:0] act_none   = 2'd0;
  localparam logic [1:0] act_config = 2'd1;
  localparam logic [1:0] act_idle   = 2'd2;

  typedef struct packed {
    logic        rst;
    logic [1:0]  act;
    logic [15:0] word;
    logic [7:0]  sets;
    logic        los;
    logic        exp_neg;
    logic        exp_send;
    logic [15:0] exp_tx_val;
  } row_t;

  logic        clk;
  logic        mr_main_reset;
  logic [7:0]  rx_byte;
  logic        rx_is_k;
  logic        los;
  logic [7:0]  tx_byte;
  logic        tx_is_k;
  logic        negotiating;
  logic [15:0] lacr_rx_val;
  logic        lacr_rx_stb;
  logic [15:0] lacr_tx_val;
  logic        lacr_send;

  logic [15:0] sent_word;
  logic        row_check;
  logic        exp_negotiating;
  logic        exp_send;
  logic [15:0] exp_tx_val;
  int          table_errors;
  int          stream_errors;
  int          rx_errors;
  int          stb_count;
  int          config_sets = 0;
  int          count_errors = 0;
  int          cycles = 0;
  int          cycle_limit;
  row_t        rows [n_rows];

  clause37_an #(
    .link_timer_ticks (timer_ticks)
  ) dut0 (
    .clk           (clk),
    .mr_main_reset (mr_main_reset),
    .rx_byte       (rx_byte),
    .rx_is_k       (rx_is_k),
    .los           (los),
    .tx_byte       (tx_byte),
    .tx_is_k       (tx_is_k),
    .negotiating   (negotiating),
    .lacr_rx_val   (lacr_rx_val),
    .lacr_rx_stb   (lacr_rx_stb),
    .lacr_tx_val   (lacr_tx_val),
    .lacr_send     (lacr_send)
  );

  an_checker chk0 (
    .clk             (clk),
    .mr_main_reset   (mr_main_reset),
    .tx_byte         (tx_byte),
    .tx_is_k         (tx_is_k),
    .negotiating     (negotiating),
    .lacr_send       (lacr_send),
    .lacr_tx_val     (lacr_tx_val),
    .lacr_rx_stb     (lacr_rx_stb),
    .lacr_rx_val     (lacr_rx_val),
    .sent_word       (sent_word),
    .row_check       (row_check),
    .exp_negotiating (exp_negotiating),
    .exp_send        (exp_send),
    .exp_tx_val      (exp_tx_val),
    .table_errors    (table_errors),
    .stream_errors   (stream_errors),
    .rx_errors       (rx_errors),
    .stb_count       (stb_count)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: no end of test after %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Rows run in order, each one starts where the previous left the engine
  task automatic load_table();
    rows[0] = '{1'b0, act_none,   16'h0000, 8'd8,   1'b0, 1'b1, 1'b1, 16'h0000};
    rows[1] = '{1'b0, act_config, 16'h0020, 8'd40,  1'b0, 1'b1, 1'b1, 16'h4020};
    rows[2] = '{1'b0, act_config, 16'h4020, 8'd12,  1'b0, 1'b1, 1'b1, 16'h4020};
    rows[3] = '{1'b0, act_idle,   16'h0000, 8'd100, 1'b0, 1'b0, 1'b0, 16'h4020};
    // Breaklink from link OK
    rows[4] = '{1'b0, act_config, 16'h0000, 8'd10,  1'b0, 1'b1, 1'b1, 16'h0000};
    rows[5] = '{1'b0, act_config, 16'h0020, 8'd40,  1'b0, 1'b1, 1'b1, 16'h4020};
    // Acknowledge with other abilities fails consistency
    rows[6] = '{1'b0, act_config, 16'h4040, 8'd12,  1'b0, 1'b1, 1'b1, 16'h0000};
    rows[7] = '{1'b1, act_none,   16'h0000, 8'd20,  1'b1, 1'b1, 1'b0, 16'h0000};
    rows[8] = '{1'b0, act_none,   16'h0000, 8'd8,   1'b0, 1'b1, 1'b1, 16'h0000};
  endtask

  task automatic apply_reset();
    @(negedge clk);
    mr_main_reset = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    mr_main_reset = 1'b0;
  endtask

  task automatic drive_byte(input logic [7:0] b, input logic k);
    @(negedge clk);
    rx_byte = b;
    rx_is_k = k;
  endtask

  task automatic send_set(input logic [1:0] act, input logic [15:0] word, input logic alt);
    if (act == act_config) begin
      drive_byte(an_code_pkg::K28_5, 1'b1);
      drive_byte(alt ? an_code_pkg::D21_5 : an_code_pkg::D2_2, 1'b0);
      drive_byte(word[7:0], 1'b0);
      drive_byte(word[15:8], 1'b0);
      sent_word = word;
      config_sets++;
    end else if (act == act_idle) begin
      drive_byte(an_code_pkg::K28_5, 1'b1);
      drive_byte(alt ? an_code_pkg::D16_2 : an_code_pkg::D5_6, 1'b0);
    end else begin
      repeat (4) drive_byte(8'h00, 1'b0);
    end
  endtask

  task automatic run_row(input row_t r);
    los = r.los;
    if (r.rst) apply_reset();
    for (int s = 0; s < int'(r.sets); s++) send_set(r.act, r.word, s[0]);
    @(negedge clk);
    rx_byte         = 8'h00;
    rx_is_k         = 1'b0;
    exp_negotiating = r.exp_neg;
    exp_send        = r.exp_send;
    exp_tx_val      = r.exp_tx_val;
    row_check       = 1'b1;
    @(negedge clk);
    row_check = 1'b0;
  endtask

  initial begin
    int total_sets;
    mr_main_reset   = 1'b1;
    rx_byte         = 8'h00;
    rx_is_k         = 1'b0;
    los             = 1'b0;
    sent_word       = 16'h0000;
    row_check       = 1'b0;
    exp_negotiating = 1'b0;
    exp_send        = 1'b0;
    exp_tx_val      = 16'h0000;
    total_sets      = 0;
    load_table();
    for (int i = 0; i < n_rows; i++) total_sets += int'(rows[i].sets);
    cycle_limit = total_sets * 4 + 4 * timer_ticks + 2 * reset_cycles;
    apply_reset();
    for (int i = 0; i < n_rows; i++) run_row(rows[i]);
    repeat (2) @(negedge clk);
    if (stb_count != config_sets) begin
      $display("Received word strobes (%0d) differ from configuration sets sent (%0d)",
               stb_count, config_sets);
      count_errors++;
    end
    $display("Errors: table %0d, tx stream %0d, rx words %0d, rx strobes %0d",
             table_errors, stream_errors, rx_errors, count_errors);
    if (table_errors + stream_errors + rx_errors + count_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+verilog
verilog/an_code_pkg.sv
verilog/an_ctrl_pkg.sv
verilog/cr_match_if.sv
verilog/cr_receiver.sv
verilog/an_arbiter.sv
verilog/os_transmitter.sv
verilog/clause37_an.sv
verif/an_checker.sv
verif/tb_clause37_an.sv

// File: Makefile
# Verilator build and run for the clause 37 auto-negotiation testbench

VERILATOR ?= verilator
TOP       ?= tb_clause37_an
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
